/* Bender.yml */
package:
  name: reg_bank

sources:
  - files:
      - hw/regBankPkg.sv
      - hw/writeBackSelect.sv
      - hw/registerFile.sv
      - hw/readPorts.sv
      - hw/regBankTop.sv
  - target: test
    files:
      - tests/regBankTb.sv

/* hw/readPorts.sv */
`timescale 1ns/100ps

module readPorts (
    input  logic                                                 fast_clock,
    input  logic                                                 reset,
    input  logic [regBankPkg::bankDepth*regBankPkg::wordSize-1:0] bankState,
    input  logic [regBankPkg::regIndexSize-1:0]                  sourceA,
    input  logic [regBankPkg::regIndexSize-1:0]                  sourceB,
    input  logic [regBankPkg::regIndexSize-1:0]                  destination,
    output logic [regBankPkg::wordSize-1:0]                      readDataA,
    output logic [regBankPkg::wordSize-1:0]                      readDataB,
    output logic [regBankPkg::wordSize-1:0]                      currentPc,
    output logic [regBankPkg::wordSize-1:0]                      currentSp,
    output logic [regBankPkg::wordSize-1:0]                      storeData
);
    import regBankPkg::*;

    logic [wordSize-1:0] wordA;
    logic [wordSize-1:0] wordB;
    logic [wordSize-1:0] wordDest;

    // Only the 16 visible registers are addressable
    assign wordA    = bankState[sourceA*wordSize +: wordSize];
    assign wordB    = bankState[sourceB*wordSize +: wordSize];
    assign wordDest = bankState[destination*wordSize +: wordSize];

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            readDataA <= '0;
            readDataB <= '0;
            currentPc <= '0;
            currentSp <= '0;
            storeData <= '0;
        end else begin
            readDataA <= wordA;
            readDataB <= wordB;
            currentPc <= bankState[pcRegister*wordSize +: wordSize];
            currentSp <= bankState[spRegister*wordSize +: wordSize];
            storeData <= wordDest; // Value for stores
        end
    end

endmodule

/* hw/regBankPkg.sv */
package regBankPkg;

    // Datapath widths
    localparam int wordSize     = 32;
    localparam int regIndexSize = 4;
    localparam int specialSize  = 4;
    localparam int opSize       = 3;

    // Architectural register map
    localparam int pcRegister = 15;
    localparam int spRegister = 14;

    // Save slots used on privilege entry
    localparam int spKeeperRegister   = 6;
    localparam int systemCallRegister = 7;
    localparam int pcKeeperRegister   = 13;

    // Hidden kernel stack pointer sits past the visible registers
    localparam int kernelStackSlot = 16;
    localparam int bankDepth       = 17;

    // Reset and jump values
    localparam logic [wordSize-1:0] userStackReset   = 32'd8191;
    localparam logic [wordSize-1:0] kernelStackReset = 32'd6143;
    localparam logic [wordSize-1:0] osStart          = 32'd2048;

    // Writeback command, codes 6 and 7 behave as opNone
    typedef enum logic [opSize-1:0] {
        opNone        = 3'd0,
        opWriteAlu    = 3'd1,
        opWriteMem    = 3'd2,
        opEnterKernel = 3'd3,
        opExitKernel  = 3'd4,
        opCopySpecial = 3'd5
    } WriteBackOp;

endpackage

/* hw/regBankTop.sv */
`timescale 1ns/100ps

module regBankTop (
    input  logic                                  fast_clock,
    input  logic                                  reset,
    input  logic                                  enable,
    input  logic [regBankPkg::opSize-1:0]         control,
    input  logic [regBankPkg::regIndexSize-1:0]   sourceA,
    input  logic [regBankPkg::regIndexSize-1:0]   sourceB,
    input  logic [regBankPkg::regIndexSize-1:0]   destination,
    input  logic [regBankPkg::wordSize-1:0]       aluResult,
    input  logic [regBankPkg::wordSize-1:0]       memoryData,
    input  logic [regBankPkg::wordSize-1:0]       newPc,
    input  logic [regBankPkg::wordSize-1:0]       newSp,
    input  logic [regBankPkg::specialSize-1:0]    specialRegister,
    output logic [regBankPkg::wordSize-1:0]       readDataA,
    output logic [regBankPkg::wordSize-1:0]       readDataB,
    output logic [regBankPkg::wordSize-1:0]       currentPc,
    output logic [regBankPkg::wordSize-1:0]       currentSp,
    output logic [regBankPkg::wordSize-1:0]       storeData
);
    import regBankPkg::*;

    WriteBackOp                  op;
    logic                        generalWrite;
    logic [wordSize-1:0]         writeData;
    logic [regIndexSize-1:0]     writeIndex;
    logic                        pcSpFollow;
    logic                        privilegeEnter;
    logic                        privilegeExit;
    logic [wordSize-1:0]         systemCall;
    logic [bankDepth*wordSize-1:0] bankState;

    writeBackSelect i_writeBackSelect (
        .enable(enable), .control(control), .destination(destination),
        .aluResult(aluResult), .memoryData(memoryData), .specialRegister(specialRegister),
        .op(op), .generalWrite(generalWrite), .writeData(writeData),
        .writeIndex(writeIndex), .pcSpFollow(pcSpFollow),
        .privilegeEnter(privilegeEnter), .privilegeExit(privilegeExit),
        .systemCall(systemCall)
    );

    registerFile i_registerFile (
        .fast_clock(fast_clock), .reset(reset), .op(op),
        .generalWrite(generalWrite), .writeIndex(writeIndex), .writeData(writeData),
        .pcSpFollow(pcSpFollow), .newPc(newPc), .newSp(newSp),
        .privilegeEnter(privilegeEnter), .privilegeExit(privilegeExit),
        .systemCall(systemCall), .bankState(bankState)
    );

    readPorts i_readPorts (
        .fast_clock(fast_clock), .reset(reset), .bankState(bankState),
        .sourceA(sourceA), .sourceB(sourceB), .destination(destination),
        .readDataA(readDataA), .readDataB(readDataB),
        .currentPc(currentPc), .currentSp(currentSp), .storeData(storeData)
    );

endmodule

/* hw/registerFile.sv */
`timescale 1ns/100ps

module registerFile (
    input  logic                                                 fast_clock,
    input  logic                                                 reset,
    input  regBankPkg::WriteBackOp                               op,
    input  logic                                                 generalWrite,
    input  logic [regBankPkg::regIndexSize-1:0]                  writeIndex,
    input  logic [regBankPkg::wordSize-1:0]                      writeData,
    input  logic                                                 pcSpFollow,
    input  logic [regBankPkg::wordSize-1:0]                      newPc,
    input  logic [regBankPkg::wordSize-1:0]                      newSp,
    input  logic                                                 privilegeEnter,
    input  logic                                                 privilegeExit,
    input  logic [regBankPkg::wordSize-1:0]                      systemCall,
    output logic [regBankPkg::bankDepth*regBankPkg::wordSize-1:0] bankState
);
    import regBankPkg::*;

    logic [wordSize-1:0] bank [bankDepth];

    always_ff @(posedge fast_clock) begin
        if (reset) begin
            bank[spRegister]      <= userStackReset;
            bank[pcRegister]      <= '0;
            bank[kernelStackSlot] <= kernelStackReset;
        end else begin
            if (generalWrite) begin
                bank[writeIndex] <= writeData;
            end

            if (pcSpFollow) begin
                bank[pcRegister] <= newPc;
                bank[spRegister] <= newSp;
            end

            if (privilegeEnter) begin
                bank[spKeeperRegister]   <= bank[spRegister]; // Save user SP
                bank[pcKeeperRegister]   <= bank[pcRegister]; // Return address
                bank[spRegister]         <= bank[kernelStackSlot];
                bank[pcRegister]         <= osStart;
                bank[systemCallRegister] <= systemCall;
            end else if (privilegeExit) begin
                bank[kernelStackSlot] <= bank[spRegister]; // Park kernel SP
                bank[spRegister]      <= bank[spKeeperRegister];
                bank[pcRegister]      <= bank[pcKeeperRegister];
            end
        end
    end

    // Flatten for the read side
    always_comb begin
        for (int i = 0; i < bankDepth; i++) begin
            bankState[i*wordSize +: wordSize] = bank[i];
        end
    end

    // PC and SP only change through follow-load or privilege swaps
    assert property (@(posedge fast_clock) disable iff (reset)
        generalWrite |-> (writeIndex != pcRegister) && (writeIndex != spRegister))
        else $error("registerFile: general write to PC or SP");

    // Follow-load must never coincide with a privilege command
    assert property (@(posedge fast_clock) disable iff (reset)
        pcSpFollow |-> !(op inside {opEnterKernel, opExitKernel}))
        else $error("registerFile: PC/SP follow-load during privilege change");

endmodule

/* hw/writeBackSelect.sv */
`timescale 1ns/100ps

module writeBackSelect (
    input  logic                                  enable,
    input  logic [regBankPkg::opSize-1:0]         control,
    input  logic [regBankPkg::regIndexSize-1:0]   destination,
    input  logic [regBankPkg::wordSize-1:0]       aluResult,
    input  logic [regBankPkg::wordSize-1:0]       memoryData,
    input  logic [regBankPkg::specialSize-1:0]    specialRegister,
    output regBankPkg::WriteBackOp                op,
    output logic                                  generalWrite,
    output logic [regBankPkg::wordSize-1:0]       writeData,
    output logic [regBankPkg::regIndexSize-1:0]   writeIndex,
    output logic                                  pcSpFollow,
    output logic                                  privilegeEnter,
    output logic                                  privilegeExit,
    output logic [regBankPkg::wordSize-1:0]       systemCall
);
    import regBankPkg::*;

    logic writesGeneral;
    logic destIsProtected;

    always_comb begin
        op = WriteBackOp'(control);
        if (control > opCopySpecial) begin
            op = opNone; // Unused codes
        end
    end

    // Data source per opcode
    always_comb begin
        case (op)
            opWriteAlu:    writeData = aluResult;
            opWriteMem:    writeData = memoryData;
            opCopySpecial: writeData = {{(wordSize - specialSize){1'b0}}, specialRegister};
            default:       writeData = '0;
        endcase
    end

    assign writesGeneral   = (op == opWriteAlu) || (op == opWriteMem) || (op == opCopySpecial);
    assign destIsProtected = (destination == pcRegister) || (destination == spRegister);

    assign generalWrite   = enable && writesGeneral && !destIsProtected;
    assign writeIndex     = destination;
    assign privilegeEnter = enable && (op == opEnterKernel);
    assign privilegeExit  = enable && (op == opExitKernel);
    assign pcSpFollow     = enable && !(op == opEnterKernel) && !(op == opExitKernel);
    assign systemCall     = aluResult; // Syscall number comes from the ALU

endmodule

/* project.f */
hw/regBankPkg.sv
hw/writeBackSelect.sv
hw/registerFile.sv
hw/readPorts.sv
hw/regBankTop.sv
tests/regBankTb.sv

/* tests/regBankTb.sv */
`timescale 1ns/100ps

module regBankTb;
    import regBankPkg::*;

    localparam int fieldCount = 17; // Words per stimulus row
    localparam int maxRows    = 64;
    localparam logic [31:0] endMarker = 32'hFFFF_FFFF;
    localparam dataPath = "tests/regBankTestdata.txt";

    logic                    fast_clock;
    logic                    reset;
    logic                    enable;
    logic [opSize-1:0]       control;
    logic [regIndexSize-1:0] sourceA;
    logic [regIndexSize-1:0] sourceB;
    logic [regIndexSize-1:0] destination;
    logic [wordSize-1:0]     aluResult;
    logic [wordSize-1:0]     memoryData;
    logic [wordSize-1:0]     newPc;
    logic [wordSize-1:0]     newSp;
    logic [specialSize-1:0]  specialRegister;
    logic [wordSize-1:0]     readDataA;
    logic [wordSize-1:0]     readDataB;
    logic [wordSize-1:0]     currentPc;
    logic [wordSize-1:0]     currentSp;
    logic [wordSize-1:0]     storeData;

    logic [31:0] vectorMem [maxRows*fieldCount];

    // Expectation of the row driven one edge earlier
    int          pendTest;
    int          pendRow;
    WriteBackOp  pendOp;
    logic [4:0]  pendMask;
    logic [31:0] pendA;
    logic [31:0] pendB;
    logic [31:0] pendPc;
    logic [31:0] pendSp;
    logic [31:0] pendStore;

    int currentTest;
    int testErrors;
    int testsPassed;
    int testsFailed;
    int mismatchCount;

    regBankTop i_dut (
        .fast_clock(fast_clock), .reset(reset), .enable(enable), .control(control),
        .sourceA(sourceA), .sourceB(sourceB), .destination(destination),
        .aluResult(aluResult), .memoryData(memoryData), .newPc(newPc), .newSp(newSp),
        .specialRegister(specialRegister),
        .readDataA(readDataA), .readDataB(readDataB), .currentPc(currentPc),
        .currentSp(currentSp), .storeData(storeData)
    );

    always #10 fast_clock = ~fast_clock;

    task automatic compareWord(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s expected 0x%08h got 0x%08h (row %0d, op %s)",
                     name, expected, actual, pendRow, pendOp.name());
            testErrors++;
            mismatchCount++;
        end
    endtask

    task automatic reportTest(input int testNumber);
        if (testErrors == 0) begin
            $display("Test %0d ok", testNumber);
            testsPassed++;
        end else begin
            $display("Test %0d failed with %0d mismatches", testNumber, testErrors);
            testsFailed++;
        end
    endtask

    task automatic checkPending();
        if (pendTest != currentTest) begin
            if (currentTest >= 0) begin
                reportTest(currentTest);
            end
            currentTest = pendTest;
            testErrors  = 0;
        end
        if (pendMask[4]) compareWord("readDataA", pendA, readDataA);
        if (pendMask[3]) compareWord("readDataB", pendB, readDataB);
        if (pendMask[2]) compareWord("currentPc", pendPc, currentPc);
        if (pendMask[1]) compareWord("currentSp", pendSp, currentSp);
        if (pendMask[0]) compareWord("storeData", pendStore, storeData);
    endtask

    task automatic driveRow(input int base);
        enable          <= vectorMem[base+2][0];
        control         <= vectorMem[base+3][opSize-1:0];
        sourceA         <= vectorMem[base+4][regIndexSize-1:0];
        sourceB         <= vectorMem[base+5][regIndexSize-1:0];
        destination     <= vectorMem[base+6][regIndexSize-1:0];
        aluResult       <= vectorMem[base+7];
        memoryData      <= vectorMem[base+8];
        newPc           <= vectorMem[base+9];
        newSp           <= vectorMem[base+10];
        specialRegister <= vectorMem[base+11][specialSize-1:0];
    endtask

    task automatic holdExpectation(input int row);
        int base;
        base      = row * fieldCount;
        pendRow   = row;
        pendTest  = vectorMem[base];
        pendMask  = vectorMem[base+1][4:0];
        pendOp    = WriteBackOp'(vectorMem[base+3][opSize-1:0]);
        pendA     = vectorMem[base+12]; // Expected values start here
        pendB     = vectorMem[base+13];
        pendPc    = vectorMem[base+14];
        pendSp    = vectorMem[base+15];
        pendStore = vectorMem[base+16];
    endtask

    initial begin : mainSequence
        int  fd;
        int  row;
        bit  fileOk;
        bit  endSeen;
        bit  havePending;
        fast_clock      = 1'b0;
        reset           = 1'b1;
        enable          = 1'b0;
        control         = '0;
        sourceA         = '0;
        sourceB         = '0;
        destination     = '0;
        aluResult       = '0;
        memoryData      = '0;
        newPc           = '0;
        newSp           = '0;
        specialRegister = '0;
        currentTest     = -1;
        testErrors      = 0;
        testsPassed     = 0;
        testsFailed     = 0;
        mismatchCount   = 0;
        endSeen         = 1'b0;
        havePending     = 1'b0;

        fd = $fopen(dataPath, "r");
        if (fd == 0) begin
            $display("Could not open the test data file %s", dataPath);
            fileOk = 1'b0;
        end else begin
            $fclose(fd);
            $readmemh(dataPath, vectorMem);
            fileOk = 1'b1;
        end

        repeat (2) @(posedge fast_clock);
        reset <= 1'b0;

        // One row per rising edge, its outputs checked at the negedge after the next one
        row = 0;
        while (fileOk && !endSeen && row < maxRows) begin
            if (vectorMem[row*fieldCount] === endMarker) begin
                endSeen = 1'b1;
                enable <= 1'b0;
                @(negedge fast_clock);
                if (havePending) begin
                    checkPending();
                end
            end else begin
                driveRow(row * fieldCount);
                @(negedge fast_clock);
                if (havePending) begin
                    checkPending();
                end
                holdExpectation(row);
                havePending = 1'b1;
                row++;
                @(posedge fast_clock);
            end
        end

        if (fileOk && !endSeen) begin
            $display("Timed out: no end marker within %0d rows of test data", maxRows);
        end
        if (currentTest >= 0) begin
            reportTest(currentTest);
        end
        $display("Summary: %0d tests ok, %0d tests with errors, %0d mismatches",
                 testsPassed, testsFailed, mismatchCount);
        if (fileOk && endSeen && testsFailed == 0 && testsPassed > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tests/regBankTestdata.txt */
// test mask en ctl srcA srcB dst alu mem newPc newSp special | expA expB expPc expSp expStore
// mask bits: 10 readDataA, 08 readDataB, 04 currentPc, 02 currentSp, 01 storeData

// Reset values
1 1f 0 0 e f e 0 0 0 0 0         1fff 0 0 1fff 1fff

// General writes from ALU, memory and special register
2 1e 1 1 e f 1 11111111 0 4 1ff0 0         1fff 0 0 1fff 0
2 1e 1 2 1 e 2 0 22222222 8 1fe0 0         11111111 1ff0 4 1ff0 0
2 1e 1 5 2 1 3 deadbeef cafef00d c 1fd0 f  22222222 11111111 8 1fe0 0
2 1f 1 0 3 2 3 0 0 10 1fc0 0               f 22222222 c 1fd0 f
2 1f 1 6 1 3 1 99999999 0 14 1fb0 0        11111111 f 10 1fc0 11111111
2 1f 0 0 1 2 3 0 0 0 0 0                   11111111 22222222 14 1fb0 f

// PC and SP as destinations
3 1f 1 1 e f f badbad01 0 18 1fa0 0        1fb0 14 14 1fb0 14
3 1f 1 2 e f e 0 badbad02 1c 1f90 0        1fa0 18 18 1fa0 1fa0
3 1f 1 5 f e f 0 0 20 1f80 7               1c 1f90 1c 1f90 1c
3 1f 0 0 e f e 0 0 0 0 0                   1f80 20 20 1f80 1f80

// Privilege entry
4 1f 1 3 e f e 42 0 bad0 bad1 0            1f80 20 20 1f80 1f80
4 1f 0 0 6 d 7 0 0 0 0 0                   1f80 20 800 17ff 42

// Exit, user code, second entry
5 1f 1 0 6 d 7 0 0 804 17f0 0              1f80 20 800 17ff 42
5 1f 1 4 e f e 0 0 bad2 bad3 0             17f0 804 804 17f0 17f0
5 1f 1 0 e f f 0 0 24 1f70 0               1f80 20 20 1f80 20
5 1f 1 3 1 2 3 99 0 bad4 bad5 0            11111111 22222222 24 1f70 f
5 1f 0 0 6 d 7 0 0 0 0 0                   1f70 24 800 17f0 99

// Commands with enable low
6 1f 0 1 1 3 1 dead0001 0 aaaa bbbb 0      11111111 f 800 17f0 11111111
6 1f 0 3 1 3 1 dead0003 0 aaaa bbbb 0      11111111 f 800 17f0 11111111
6 1f 0 4 1 3 1 0 0 aaaa bbbb 0             11111111 f 800 17f0 11111111
6 1f 0 2 6 7 d 0 dead0002 aaaa bbbb 5      1f70 99 800 17f0 24
6 1f 0 0 d e f 0 0 0 0 0                   24 17f0 800 17f0 800

// End marker
ffffffff 0 0 0 0 0 0 0 0 0 0 0             0 0 0 0 0
